//--- run_sim.sh
#!/bin/sh
# Builds the data cache testbench with Verilator and runs it
set -e
verilator --binary --timing --assert -f tb.f --top-module tb_dcache -o tb_dcache
./obj_dir/tb_dcache

//--- src/cache_way.sv
// Cache way with per-set tag, valid and line storage plus the hit compare
`default_nettype none

`include "dcache_defs.svh"

module cache_way
    import mem_bus_pkg::*;
    import dcache_pkg::*;
(
    input  wire logic        clk,
    input  wire logic        rst_n,
    input  wire way_lookup_t lookup,
    input  wire way_fill_t   fill,
    input  wire logic        wr_en,
    input  wire way_inv_t    inv_req,
    output way_status_t      status
);

    tag_t                tag_mem  [`DC_SETS];
    line_t               line_mem [`DC_SETS];
    logic [`DC_SETS-1:0] valid;
    line_t               rd_line;
    set_t                inv_set;
    tag_t                inv_tag;

    assign {inv_tag, inv_set} = inv_req.blk;

    always_ff @(posedge clk) begin
        if (wr_en) begin
            line_mem[fill.set] <= fill.line;
        end
        // A fill landing in the looked-up set is forwarded to the read port
        if (wr_en && fill.set == lookup.set) begin
            rd_line <= fill.line;
        end else begin
            rd_line <= line_mem[lookup.set];
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en && fill.fill) begin
            tag_mem[fill.set] <= fill.tag;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid <= '0;
        end else begin
            if (inv_req.inv && tag_mem[inv_set] == inv_tag) begin
                valid[inv_set] <= 1'b0;
            end
            if (wr_en && fill.fill) begin
                valid[fill.set] <= 1'b1; // A fill wins over an invalidation
            end
        end
    end

    assign status.valid = valid[lookup.set];
    assign status.hit   = valid[lookup.set] && tag_mem[lookup.set] == lookup.tag;
    assign status.line  = rd_line;

endmodule

`default_nettype wire

//--- src/dcache_ctrl.sv
// Cache controller with the access FSM, miss fetch, victim choice and store path
`default_nettype none

`include "dcache_defs.svh"

module dcache_ctrl
    import mem_bus_pkg::*;
    import dcache_pkg::*;
(
    input  wire logic                  clk,
    input  wire logic                  rst_n,
    input  wire logic [`DC_ADDR_W-1:0] addr,
    input  wire access_len_t           len,
    input  wire logic [63:0]           data_in,
    input  wire logic                  rd,
    input  wire logic                  wr,
    output logic                       ld_ma,
    output logic                       st_ma,
    output logic                       stall,
    input  wire logic                  hit,
    input  wire logic [`DC_WAY_W-1:0]  hit_way,
    input  wire line_t                 sel_line,
    input  wire logic [`DC_WAYS-1:0]   way_valid,
    output way_lookup_t                lookup,
    output way_fill_t                  fill,
    output logic [`DC_WAYS-1:0]        way_wr_en,
    output logic                       mem_rd,
    output blk_addr_t                  mem_blk_addr,
    input  wire logic                  mem_valid,
    input  wire line_t                 mem_line,
    output mem_write_t                 mem_wr_o
);

    localparam int LINE_BYTES = `DC_LINE_BYTES;

    ctrl_state_t               state;
    ctrl_state_t               state_next;
    tag_t                      a_tag;
    set_t                      a_set;
    offs_t                     a_offs;
    logic                      misaligned;
    logic                      access_ok;
    logic                      fill_now;
    logic                      store_now;
    logic [7:0]                size_be;
    logic [`DC_LINE_BYTES-1:0] line_be;
    line_t                     line_wdata;
    line_t                     merged;
    logic [`DC_WAY_W-1:0]      victim;
    logic [`DC_WAY_W-1:0]      rr_cnt;

    assign {a_tag, a_set, a_offs} = addr;

    always_comb begin
        case (len[1:0])
            2'd0:    size_be = 8'h01;
            2'd1:    size_be = 8'h03;
            2'd2:    size_be = 8'h0f;
            default: size_be = 8'hff;
        endcase
    end

    // Bits 4, 2 and 1 of the byte mask form the low-address alignment mask
    assign misaligned = |(addr[2:0] & {size_be[4], size_be[2], size_be[1]});

    assign access_ok = state == s_ready && (rd || wr) && !misaligned;
    assign fill_now  = state == s_fetch && mem_valid;
    assign store_now = state == s_load && wr;

    assign ld_ma = state == s_ready && rd && misaligned;
    assign st_ma = state == s_ready && wr && misaligned;
    assign stall = access_ok || state == s_fetch;

    always_comb begin
        state_next = state;
        case (state)
            s_ready: if (access_ok) state_next = hit ? s_load : s_fetch;
            s_fetch: if (mem_valid) state_next = s_load;
            default: state_next = s_ready; // s_load finishes in one cycle
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state  <= s_ready;
            rr_cnt <= '0;
        end else begin
            state <= state_next;
            if (fill_now) begin
                rr_cnt <= rr_cnt + 1'b1;
            end
        end
    end

    // Lowest invalid way first, otherwise the round-robin pointer
    always_comb begin
        victim = rr_cnt;
        for (int w = `DC_WAYS - 1; w >= 0; w--) begin
            if (!way_valid[w]) begin
                victim = w[`DC_WAY_W-1:0];
            end
        end
    end

    // Store bytes placed at their line position and merged over the hit line
    assign line_be    = LINE_BYTES'(size_be) << a_offs;
    assign line_wdata = line_t'(data_in) << {a_offs, 3'b000};

    always_comb begin
        for (int b = 0; b < LINE_BYTES; b++) begin
            merged[8*b +: 8] = line_be[b] ? line_wdata[8*b +: 8] : sel_line[8*b +: 8];
        end
    end

    always_comb begin
        lookup.set = a_set;
        lookup.tag = a_tag;
        fill.fill  = fill_now;
        fill.set   = a_set;
        fill.tag   = a_tag;
        fill.line  = fill_now ? mem_line : merged;
        way_wr_en  = '0;
        if (fill_now) begin
            way_wr_en[victim] = 1'b1;
        end else if (store_now) begin
            way_wr_en[hit_way] = 1'b1;
        end
    end

    assign mem_rd       = state == s_fetch; // Held until mem_valid
    assign mem_blk_addr = {a_tag, a_set};

    always_comb begin
        mem_wr_o.wr   = store_now;
        mem_wr_o.addr = addr[`DC_ADDR_W-1:3];
        mem_wr_o.data = data_in << {addr[2:0], 3'b000};
        mem_wr_o.be   = size_be << addr[2:0];
    end

endmodule

`default_nettype wire

//--- src/dcache_defs.svh
// L1 data cache geometry, with the address field widths derived from it
`ifndef DCACHE_DEFS_SVH
`define DCACHE_DEFS_SVH

`define DC_ADDR_W       32 // Byte address width
`define DC_WAYS         4
`define DC_SETS         16
`define DC_LINE_BYTES   16

// Field widths of a byte address, split as {tag, set, offset}
`define DC_OFFS_W       $clog2(`DC_LINE_BYTES)
`define DC_SET_W        $clog2(`DC_SETS)
`define DC_WAY_W        $clog2(`DC_WAYS)
`define DC_BLK_W        (`DC_ADDR_W - `DC_OFFS_W)
`define DC_TAG_W        (`DC_BLK_W - `DC_SET_W)

// Line width in bits
`define DC_LINE_W       (8 * `DC_LINE_BYTES)

`endif

//--- src/dcache_pkg.sv
// Data cache types for address fields, way requests and the controller FSM
`default_nettype none

`include "dcache_defs.svh"

package dcache_pkg;

    import mem_bus_pkg::*;

    typedef logic [`DC_TAG_W-1:0]  tag_t;
    typedef logic [`DC_SET_W-1:0]  set_t;
    typedef logic [`DC_OFFS_W-1:0] offs_t;

    // Bit 2 selects zero extension, bits 1:0 give 1, 2, 4 or 8 bytes
    typedef logic [2:0] access_len_t;

    // Lookup presented to every way in parallel
    typedef struct packed {
        set_t set;
        tag_t tag;
    } way_lookup_t;

    // Line write, qualified per way by a separate write enable
    typedef struct packed {
        logic  fill;  // Also writes the tag and sets valid
        set_t  set;
        tag_t  tag;
        line_t line;
    } way_fill_t;

    typedef struct packed {
        logic      inv;
        blk_addr_t blk;
    } way_inv_t;

    typedef struct packed {
        logic  hit;
        logic  valid; // Valid bit of the looked-up set
        line_t line;  // Registered read, one cycle behind the lookup
    } way_status_t;

    typedef enum logic [1:0] {
        s_ready,
        s_fetch,
        s_load
    } ctrl_state_t;

endpackage

`default_nettype wire

//--- src/dcache_top.sv
// L1 data cache top level joining the controller, the ways and the selector
`default_nettype none

`include "dcache_defs.svh"

module dcache_top
    import mem_bus_pkg::*;
    import dcache_pkg::*;
(
    input  wire logic                  clk,
    input  wire logic                  rst_n,
    input  wire logic [`DC_ADDR_W-1:0] addr,
    input  wire access_len_t           len,
    input  wire logic [63:0]           data_in,
    input  wire logic                  rd,
    input  wire logic                  wr,
    output logic [63:0]                data_out,
    output logic                       ld_ma,
    output logic                       st_ma,
    output logic                       stall,
    output logic                       mem_rd,
    output blk_addr_t                  mem_blk_addr,
    input  wire logic                  mem_valid,
    input  wire line_t                 mem_line,
    output mem_write_t                 mem_wr_o,
    input  wire logic                  inv,
    input  wire blk_addr_t             inv_addr
);

    way_lookup_t           lookup;
    way_fill_t             fill;
    way_inv_t              inv_req;
    logic [`DC_WAYS-1:0]   way_wr_en;
    way_status_t           status [`DC_WAYS];
    logic                  hit;
    logic [`DC_WAY_W-1:0]  hit_way;
    line_t                 sel_line;
    logic [`DC_WAYS-1:0]   way_valid;

    assign inv_req = '{inv: inv, blk: inv_addr};

    dcache_ctrl dcache_ctrl_inst (
        .clk, .rst_n, .addr, .len, .data_in, .rd, .wr,
        .ld_ma, .st_ma, .stall,
        .hit, .hit_way, .sel_line, .way_valid,
        .lookup, .fill, .way_wr_en,
        .mem_rd, .mem_blk_addr, .mem_valid, .mem_line, .mem_wr_o
    );

    for (genvar w = 0; w < `DC_WAYS; w++) begin : g_way
        cache_way cache_way_inst (
            .clk, .rst_n, .lookup, .fill,
            .wr_en  (way_wr_en[w]),
            .inv_req,
            .status (status[w])
        );
    end

    way_select way_select_inst (
        .status, .offs(addr[`DC_OFFS_W-1:0]), .len,
        .hit, .hit_way, .sel_line, .way_valid, .data_out
    );

endmodule

`default_nettype wire

//--- src/mem_bus_pkg.sv
// Memory bus types shared by the cache and the backing memory
`default_nettype none

`include "dcache_defs.svh"

package mem_bus_pkg;

    typedef logic [`DC_BLK_W-1:0]  blk_addr_t; // Address of a whole line
    typedef logic [`DC_LINE_W-1:0] line_t;

    // Double-word address, the byte address without its low three bits
    typedef logic [`DC_ADDR_W-4:0] dw_addr_t;

    // One-cycle write-through strobe, always accepted by memory
    typedef struct packed {
        logic        wr;
        dw_addr_t    addr;
        logic [63:0] data; // Bytes already placed at their lane
        logic [7:0]  be;
    } mem_write_t;

endpackage

`default_nettype wire

//--- src/way_select.sv
// Way status reduction to hit, hit way and line, plus load extraction
`default_nettype none

`include "dcache_defs.svh"

module way_select
    import mem_bus_pkg::*;
    import dcache_pkg::*;
(
    input  wire way_status_t          status [`DC_WAYS],
    input  wire offs_t                offs,
    input  wire access_len_t          len,
    output logic                      hit,
    output logic [`DC_WAY_W-1:0]      hit_way,
    output line_t                     sel_line,
    output logic [`DC_WAYS-1:0]       way_valid,
    output logic [63:0]               data_out
);

    line_t       shifted;
    logic [63:0] raw;

    // Lowest way index wins, although a tag lives in one way only
    always_comb begin
        hit     = 1'b0;
        hit_way = '0;
        for (int w = `DC_WAYS - 1; w >= 0; w--) begin
            way_valid[w] = status[w].valid;
            if (status[w].hit) begin
                hit     = 1'b1;
                hit_way = w[`DC_WAY_W-1:0];
            end
        end
    end

    assign sel_line = status[hit_way].line;

    assign shifted = sel_line >> {offs, 3'b000}; // Addressed byte moved to bit 0
    assign raw     = shifted[63:0];

    always_comb begin
        case (len)
            3'b000:  data_out = {{56{raw[7]}}, raw[7:0]};
            3'b001:  data_out = {{48{raw[15]}}, raw[15:0]};
            3'b010:  data_out = {{32{raw[31]}}, raw[31:0]};
            3'b100:  data_out = {56'b0, raw[7:0]};
            3'b101:  data_out = {48'b0, raw[15:0]};
            3'b110:  data_out = {32'b0, raw[31:0]};
            default: data_out = raw; // Double word, signed or not
        endcase
    end

endmodule

`default_nettype wire

//--- tb.f
+incdir+src
src/mem_bus_pkg.sv
src/dcache_pkg.sv
src/cache_way.sv
src/way_select.sv
src/dcache_ctrl.sv
src/dcache_top.sv
testbench/tb_mem_model.sv
testbench/tb_dcache.sv

//--- testbench/tb_dcache.sv
// Testbench for the L1 data cache, checking loads and write-through against a shadow memory
`default_nettype none

module tb_dcache
    import mem_bus_pkg::*;
    import dcache_pkg::*;
();

    localparam logic [31:0] REGION_BASE    = 32'h0004_0000;
    localparam int          REGION_BYTES   = 4096; // Four times the cache capacity
    localparam int          RANDOM_OPS     = 1000;
    localparam int          MAX_OPS        = 1500; // Accesses over all tests, rounded up
    localparam int          TIMEOUT_CYCLES = MAX_OPS * 16 + 6000;
    localparam logic [31:0] SEED           = 32'h947b;

    logic        clk;
    logic        rst_n;
    logic [31:0] addr;
    access_len_t len;
    logic [63:0] data_in;
    logic        rd;
    logic        wr;
    logic [63:0] data_out;
    logic        ld_ma;
    logic        st_ma;
    logic        stall;
    logic        mem_rd;
    blk_addr_t   mem_blk_addr;
    logic        mem_valid;
    line_t       mem_line;
    mem_write_t  mem_wr_o;
    logic        inv;
    blk_addr_t   inv_addr;
    logic [2:0]  mem_delay;
    mem_write_t  poke;
    logic [7:0]  shadow [REGION_BYTES];
    logic [31:0] lfsr   = SEED;
    int          cycles = 0;
    logic [11:0] off;
    access_len_t l;

    dcache_top dcache_top_inst (.*);

    tb_mem_model mem_model_inst (
        .clk, .rst_n, .delay(mem_delay), .mem_rd, .mem_blk_addr,
        .mem_valid, .mem_line, .mem_wr(mem_wr_o), .poke
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]}; // Taps 32, 22, 2 and 1
    endfunction

    function automatic logic [63:0] random_bits(input int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v    = {v[62:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic int size_of(input access_len_t code);
        return 1 << code[1:0];
    endfunction

    function automatic logic misaligned(input logic [31:0] a, input access_len_t code);
        return (a[2:0] & 3'(size_of(code) - 1)) != 3'b000;
    endfunction

    function automatic logic [11:0] aligned_offset(input access_len_t code);
        return 12'(random_bits(12)) & ~12'(size_of(code) - 1);
    endfunction

    // Little-endian bytes from the shadow memory, then sign or zero extension
    function automatic logic [63:0] expected_load(input logic [11:0] a, input access_len_t code);
        logic [63:0] v;
        int          sh;
        v  = '0;
        sh = 64 - 8 * size_of(code);
        for (int i = size_of(code) - 1; i >= 0; i--) begin
            v = {v[55:0], shadow[a + 12'(i)]};
        end
        if (!code[2]) begin
            v = $signed(v << sh) >>> sh;
        end
        return v;
    endfunction

    task automatic fail_check(input string what);
        $display("error at %0t: %s", $time, what);
        $display("Errors found");
        $fatal(1, "Stopped at the first failing check");
    endtask

    task automatic write_shadow(input logic [11:0] a, input int size, input logic [63:0] d);
        logic [63:0] bytes;
        bytes = d;
        for (int i = 0; i < size; i++) begin
            shadow[a + 12'(i)] = bytes[7:0];
            bytes              = bytes >> 8;
        end
    endtask

    task automatic check_memory();
        for (int i = 0; i < REGION_BYTES; i++) begin
            assert (mem_model_inst.mem[i] == shadow[i])
                else fail_check($sformatf("memory byte %h holds %h, shadow has %h",
                                          i, mem_model_inst.mem[i], shadow[i]));
        end
    endtask

    // One core request, held until stall drops, followed by an idle cycle
    task automatic run_access(input logic is_store, input logic [11:0] a,
                              input access_len_t code, input logic [63:0] d);
        @(posedge clk);
        rd        <= !is_store;
        wr        <= is_store;
        addr      <= REGION_BASE | {20'b0, a};
        len       <= code;
        data_in   <= d;
        mem_delay <= 3'(random_bits(3));
        @(negedge clk);
        while (stall) @(negedge clk);
        if (is_store && !misaligned({20'b0, a}, code)) begin
            write_shadow(a, size_of(code), d);
        end
        @(posedge clk);
        rd <= 1'b0;
        wr <= 1'b0;
        @(negedge clk);
        check_memory();
    endtask

    // Changes a double word behind the cache, then invalidates its block
    task automatic replace_behind_cache(input logic [11:0] a, input logic [63:0] d);
        logic [31:0] full;
        full = REGION_BASE | {20'b0, a};
        @(posedge clk);
        poke <= '{wr: 1'b1, addr: full[31:3], data: d, be: 8'hff};
        write_shadow(a, 8, d);
        @(posedge clk);
        poke     <= '0;
        inv      <= 1'b1;
        inv_addr <= full[31:4];
        @(posedge clk);
        inv <= 1'b0;
    endtask

    always @(negedge clk) begin
        if (rst_n && mem_rd) begin
            assert (mem_blk_addr == addr[31:4])
                else fail_check($sformatf("line read of block %h for access at %h",
                                          mem_blk_addr, addr));
        end
        if (rst_n && (rd || wr) && !stall) begin
            if (misaligned(addr, len)) begin
                assert (ld_ma == rd && st_ma == wr && !mem_wr_o.wr && !mem_rd)
                    else fail_check($sformatf("misaligned access at %h not flagged", addr));
            end else if (rd) begin
                assert (!ld_ma && data_out == expected_load(addr[11:0], len))
                    else fail_check($sformatf("load %h len %0d gave %h, expected %h", addr,
                                              len, data_out, expected_load(addr[11:0], len)));
            end else begin
                assert (!st_ma && mem_wr_o.wr && mem_wr_o.addr == addr[31:3] &&
                        mem_wr_o.be == (8'hff >> (8 - size_of(len))) << addr[2:0])
                    else fail_check($sformatf("store %h len %0d sent strobe %h",
                                              addr, len, mem_wr_o));
            end
        end else if (rst_n && !rd && !wr) begin
            assert (!stall && !mem_rd && !mem_wr_o.wr)
                else fail_check("stall or bus activity while the core is idle");
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Errors found");
            $fatal(1, "The run did not finish within %0d cycles", TIMEOUT_CYCLES);
        end
    end

    initial begin
        rst_n     <= 1'b0;
        rd        <= 1'b0;
        wr        <= 1'b0;
        addr      <= REGION_BASE;
        len       <= '0;
        data_in   <= '0;
        inv       <= 1'b0;
        inv_addr  <= '0;
        mem_delay <= '0;
        poke      <= '0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        for (int i = 0; i < REGION_BYTES; i++) begin
            shadow[i] = mem_model_inst.mem[i];
        end
        for (int rep = 0; rep < 4; rep++) begin
            for (int n = 0; n < 8; n++) begin
                off = aligned_offset(3'(n));
                run_access(1'b0, off, 3'(n), '0);
                run_access(1'b0, off, 3'(n), '0); // Same line again, now a hit
            end
        end
        repeat (100) begin
            l   = 3'(random_bits(3));
            off = aligned_offset(l);
            run_access(1'b1, off, l, random_bits(64));
            run_access(1'b0, off, l, '0);
        end
        repeat (RANDOM_OPS) begin
            l = 3'(random_bits(3));
            run_access(1'(random_bits(1)), aligned_offset(l), l, random_bits(64));
        end
        repeat (100) begin
            l = 3'(random_bits(3));
            if (l[1:0] == 2'b00) begin
                l[1:0] = 2'b01; // Single bytes are never misaligned
            end
            off = 12'(random_bits(12));
            if (!misaligned({20'b0, off}, l)) begin
                off[0] = 1'b1;
            end
            run_access(1'(random_bits(1)), off, l, random_bits(64));
        end
        repeat (20) begin
            off = aligned_offset(3'b011);
            run_access(1'b0, off, 3'b011, '0);
            replace_behind_cache(off, random_bits(64));
            run_access(1'b0, off, 3'b011, '0);
        end
        $display("No errors");
        $finish;
    end

endmodule

`default_nettype wire

//--- testbench/tb_mem_model.sv
// Backing memory model with delayed line reads, write-through strobes and direct pokes
`default_nettype none

module tb_mem_model
    import mem_bus_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       rst_n,
    input  wire logic [2:0] delay,      // Extra cycles before a line read answers
    input  wire logic       mem_rd,
    input  wire blk_addr_t  mem_blk_addr,
    output logic            mem_valid,
    output line_t           mem_line,
    input  wire mem_write_t mem_wr,
    input  wire mem_write_t poke        // Bypasses the cache entirely
);

    logic [7:0] mem [4096]; // One 4 KB region, indexed by the low address bits
    logic [2:0] wait_cnt;
    line_t      rd_line;

    always_comb begin
        for (int k = 0; k < 16; k++) begin
            rd_line[8*k +: 8] = mem[{mem_blk_addr[7:0], 4'(k)}];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mem_valid <= 1'b0;
            wait_cnt  <= '0;
            for (int i = 0; i < 4096; i++) begin
                mem[i] <= 8'(i) ^ 8'(i >> 4) ^ 8'h5a; // Every address bit shapes the byte
            end
        end else begin
            mem_valid <= 1'b0;
            // The read stays requested during the pulse, so a new wait starts only after it
            if (mem_rd && !mem_valid) begin
                if (wait_cnt == delay) begin
                    mem_valid <= 1'b1;
                    mem_line  <= rd_line;
                    wait_cnt  <= '0;
                end else begin
                    wait_cnt <= wait_cnt + 3'd1;
                end
            end
            for (int k = 0; k < 8; k++) begin
                if (mem_wr.wr && mem_wr.be[k]) begin
                    mem[{mem_wr.addr[8:0], 3'(k)}] <= mem_wr.data[8*k +: 8];
                end
                if (poke.wr && poke.be[k]) begin
                    mem[{poke.addr[8:0], 3'(k)}] <= poke.data[8*k +: 8];
                end
            end
        end
    end

endmodule

`default_nettype wire
